//--- Makefile
# Verilator build and run of the bus subsystem testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f soc_bus_top.f \
		--top-module soc_bus_tb -o soc_bus_sim
	./obj_dir/soc_bus_sim | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/soc_bus_tb.sv
`timescale 1ns/1ns

module soc_bus_tb;
    import soc_pkg::*;

    localparam logic [1:0] k_write      = 2'd0;
    localparam logic [1:0] k_read       = 2'd1;
    localparam logic [1:0] k_read_stall = 2'd2;
    localparam logic [1:0] k_leds       = 2'd3;

    logic  clk;
    logic  rst;
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t dat_w;
    sel_t  sel;
    word_t dat_r;
    logic  ack;
    byte_t leds;
    logic  serial;

    // entry i of the stimulus table is spread over index i of every queue.
    logic [1:0] kind_q [$];
    addr_t      adr_q [$];
    word_t      wdata_q [$];
    sel_t       sel_q [$];
    word_t      exp_q [$];
    int         test_q [$];

    word_t rom_model [0:15];
    word_t ram_model [0:255];
    logic  table_ready = 1'b0;
    int    cur_test = 0;
    int    test_errors = 0;
    int    n_pass = 0;
    int    n_fail = 0;

    // tx is looped straight back into rx.
    soc_bus_top i_dut (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack), .leds(leds),
        .tx(serial), .rx(serial)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // models and table construction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input sel_t s);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_entry(input logic [1:0] kind, input addr_t a, input word_t d,
                             input sel_t s, input word_t e, input int t);
        kind_q.push_back(kind);
        adr_q.push_back(a);
        wdata_q.push_back(d);
        sel_q.push_back(s);
        exp_q.push_back(e);
        test_q.push_back(t);
    endtask

    task automatic build_table();
        byte_t picks [6] = '{8'd0, 8'd1, 8'd7, 8'd42, 8'd128, 8'd255};
        sel_t  lanes [6] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0101, 4'b0011};
        byte_t echo [3] = '{8'h5a, 8'ha5, 8'h3c};
        byte_t sent [$];
        word_t rng;
        addr_t a;
        rng = 32'hc6c9;
        for (int i = 0; i < 16; i++) begin
            a = 32'h1000_0000 + {26'd0, i[3:0], 2'b00};
            add_entry(k_read, a, '0, 4'hf, rom_model[i], 1);
        end
        add_entry(k_write, 32'h1000_000c, 32'hdead_beef, 4'hf, '0, 1);
        add_entry(k_read, 32'h1000_000c, '0, 4'hf, rom_model[3], 1);
        // full words first, so that every lane has a known value before the merges.
        for (int j = 0; j < 6; j++) begin
            rng = xorshift(rng);
            ram_model[picks[j]] = rng;
            add_entry(k_write, 32'h2000_0000 + {22'd0, picks[j], 2'b00}, rng, 4'hf, '0, 2);
        end
        for (int j = 0; j < 6; j++) begin
            rng = xorshift(rng);
            ram_model[picks[j]] = merge_lanes(ram_model[picks[j]], rng, lanes[j]);
            add_entry(k_write, 32'h2000_0000 + {22'd0, picks[j], 2'b00}, rng, lanes[j], '0, 2);
        end
        for (int j = 0; j < 6; j++) begin
            a = 32'h2000_0000 + {22'd0, picks[j], 2'b00};
            add_entry(k_read, a, '0, 4'hf, ram_model[picks[j]], 2);
        end
        add_entry(k_write, 32'h3000_0000, 32'h1234_56c3, 4'hf, '0, 3);
        add_entry(k_leds, '0, '0, '0, 32'h0000_00c3, 3);
        add_entry(k_read, 32'h3000_0000, '0, 4'hf, 32'h0000_00c3, 3);
        add_entry(k_read, 32'h5000_0000, '0, 4'hf, 32'd2, 4);
        for (int j = 0; j < 3; j++) begin
            add_entry(k_write, 32'h4000_0000, {24'd0, echo[j]}, 4'hf, '0, 4);
        end
        add_entry(k_read_stall, 32'h4000_0000, '0, 4'hf, {24'd0, echo[0]}, 4);
        add_entry(k_read, 32'h4000_0000, '0, 4'hf, {24'd0, echo[1]}, 4);
        add_entry(k_read, 32'h4000_0000, '0, 4'hf, {24'd0, echo[2]}, 4);
        for (int j = 0; j < 17; j++) begin
            rng = xorshift(rng);
            sent.push_back(rng[7:0]);
            add_entry(k_write, 32'h4000_0000, rng, 4'hf, '0, 5);
        end
        // one byte is on the line and sixteen wait in the FIFO before any byte has come back.
        add_entry(k_read, 32'h5000_0000, '0, 4'hf, 32'd3, 5);
        for (int j = 0; j < 17; j++) begin
            add_entry(k_read, 32'h4000_0000, '0, 4'hf, {24'd0, sent[j]}, 5);
        end
        add_entry(k_read, 32'h0000_0000, '0, 4'hf, '0, 6);
        add_entry(k_read, 32'h6000_0004, '0, 4'hf, '0, 6);
        add_entry(k_write, 32'h7000_0000, 32'hffff_ffff, 4'hf, '0, 6);
        add_entry(k_read, 32'h7000_0000, '0, 4'hf, '0, 6);
        add_entry(k_read, 32'hf000_00fc, '0, 4'hf, '0, 6);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus master and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // starts on a falling edge and holds stb over the rising edge that samples ack.
    task automatic bus_access(input logic write, input addr_t a, input word_t d,
                              input sel_t s, output word_t rd, output int waited);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = a;
        dat_w = d;
        sel   = s;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack);
        rd = dat_r;
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_entry(input int i);
        word_t rd;
        int    waited;
        if (kind_q[i] == k_leds) begin
            if (leds !== exp_q[i][7:0]) begin
                $display("mismatch at %0t ns: test %0d leds %h, expected %h",
                         $time, test_q[i], leds, exp_q[i][7:0]);
                test_errors++;
            end
        end else begin
            bus_access(kind_q[i] == k_write, adr_q[i], wdata_q[i], sel_q[i], rd, waited);
            if (kind_q[i] != k_write && rd !== exp_q[i]) begin
                $display("mismatch at %0t ns: test %0d read %h from %h, expected %h",
                         $time, test_q[i], rd, adr_q[i], exp_q[i]);
                test_errors++;
            end
            if (kind_q[i] == k_read_stall && waited < 4) begin
                $display("test %0d: read at %h returned before any byte could arrive",
                         test_q[i], adr_q[i]);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input int t);
        if (test_errors == 0) begin
            $display("test %0d done, no errors", t);
            n_pass++;
        end else begin
            $display("test %0d done, %0d errors", t, test_errors);
            n_fail++;
        end
        test_errors = 0;
    endtask

    initial begin
        wait (table_ready);
        repeat (kind_q.size() * 200) @(posedge clk);
        $display("timeout: test %0d never got an ack from the bus", cur_test);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = '0;
        $readmemh("rom.hex", rom_model);
        build_table();
        table_ready = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < kind_q.size(); i++) begin
            cur_test = test_q[i];
            run_entry(i);
            if (i == kind_q.size() - 1 || test_q[i + 1] != cur_test) begin
                finish_test(cur_test);
            end
        end
        $display("tests without errors: %0d, tests with errors: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- rom.hex
// one 32-bit ROM word per line, word address 0 first
00000013
10000537
00a00593
00b52023
00052603
fe061ee3
40000693
00c6a023
00168693
ff9ff06f
deadc0de
12345678
87654321
a5a55a5a
0f0f0f0f
f0e1d2c3

//--- soc_bus_top.f
verilog/soc_pkg.sv
verilog/byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_port.sv
verilog/soc_memory.sv
verilog/soc_interconnect.sv
verilog/soc_bus_top.sv
bench/soc_bus_tb.sv

//--- verilog/byte_fifo.sv
`timescale 1ns/1ns

module byte_fifo (
    input  logic           clk,
    input  logic           rst,
    input  logic           push,
    input  logic           pop,
    input  soc_pkg::byte_t wdata,
    output soc_pkg::byte_t rdata,
    output logic           full,
    output logic           empty
);
    import soc_pkg::*;

    byte_t mem [0:(1 << fifo_bits) - 1];

    logic [fifo_bits-1:0] wr_ptr;
    logic [fifo_bits-1:0] rd_ptr;
    logic [fifo_bits:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign full  = count[fifo_bits];
    assign empty = (count == '0);

    // a full FIFO still takes a byte when the head leaves in the same cycle.
    assign do_push = push && (!full || pop);
    assign do_pop  = pop && !empty;

    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

    no_push_full: assert property (@(posedge clk) disable iff (rst) (push && full) |-> pop);

endmodule

//--- verilog/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  soc_pkg::addr_t adr,
    input  soc_pkg::word_t dat_w,
    input  soc_pkg::sel_t  sel,
    output soc_pkg::word_t dat_r,
    output logic           ack,
    output soc_pkg::byte_t leds,
    output logic           tx,
    input  logic           rx
);
    import soc_pkg::*;

    word_t mem_rdata;
    word_t uart_rdata;
    logic  mem_stb;
    logic  mem_rom_sel;
    logic  mem_ack;
    logic  uart_stb;
    logic  uart_status_sel;
    logic  uart_ack;

    soc_interconnect i_interconnect (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .adr(adr), .dat_w(dat_w), .we(we),
        .dat_r(dat_r), .ack(ack), .leds(leds),
        .mem_stb(mem_stb), .mem_rom_sel(mem_rom_sel),
        .uart_stb(uart_stb), .uart_status_sel(uart_status_sel),
        .mem_rdata(mem_rdata), .uart_rdata(uart_rdata),
        .mem_ack(mem_ack), .uart_ack(uart_ack)
    );

    soc_memory i_memory (
        .clk(clk), .rst(rst), .mem_stb(mem_stb), .mem_rom_sel(mem_rom_sel), .we(we),
        .adr(adr), .dat_w(dat_w), .sel(sel), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
    );

    uart_port i_uart (
        .clk(clk), .rst(rst), .uart_stb(uart_stb), .uart_status_sel(uart_status_sel),
        .we(we), .dat_w(dat_w), .uart_rdata(uart_rdata), .uart_ack(uart_ack),
        .tx(tx), .rx(rx)
    );

endmodule

//--- verilog/soc_interconnect.sv
`timescale 1ns/1ns

module soc_interconnect (
    input  logic           clk,
    input  logic           rst,
    input  logic           cyc,
    input  logic           stb,
    input  soc_pkg::addr_t adr,
    input  soc_pkg::word_t dat_w,
    input  logic           we,
    output soc_pkg::word_t dat_r,
    output logic           ack,
    output soc_pkg::byte_t leds,
    output logic           mem_stb,
    output logic           mem_rom_sel,
    output logic           uart_stb,
    output logic           uart_status_sel,
    input  soc_pkg::word_t mem_rdata,
    input  soc_pkg::word_t uart_rdata,
    input  logic           mem_ack,
    input  logic           uart_ack
);
    import soc_pkg::*;

    region_t region;
    region_t region_q;
    logic    req;
    logic    is_mem;
    logic    is_uart;
    logic    local_stb;
    logic    local_ack;

    assign region  = adr[31:region_start_bit];
    assign req     = cyc && stb;
    assign is_mem  = (region == region_rom) || (region == region_ram);
    assign is_uart = (region == region_uart_data) || (region == region_uart_status);

    assign mem_stb         = req && is_mem;
    assign mem_rom_sel     = (region == region_rom);
    assign uart_stb        = req && is_uart;
    assign uart_status_sel = (region == region_uart_status);

    // LED and unmapped accesses are answered here.
    assign local_stb = req && !is_mem && !is_uart;

    always_ff @(posedge clk) begin
        if (rst) begin
            local_ack <= 1'b0;
            region_q  <= '0;
            leds      <= '0;
        end else begin
            local_ack <= local_stb && !local_ack;
            if (req) begin
                region_q <= region;
            end
            if (local_stb && !local_ack && we && region == region_led) begin
                leds <= dat_w[7:0];
            end
        end
    end

    assign ack = mem_ack || uart_ack || local_ack;

    always_comb begin
        case (region_q)
            region_rom, region_ram:                 dat_r = mem_rdata;
            region_uart_data, region_uart_status:   dat_r = uart_rdata;
            region_led:                             dat_r = word_t'(leds);
            default:                                dat_r = '0;
        endcase
    end

    // the master keeps stb up until it has seen ack.
    ack_needs_stb: assert property (@(posedge clk) disable iff (rst) ack |-> stb);

    one_target: assert property (@(posedge clk) disable iff (rst) !(mem_stb && uart_stb));

endmodule

//--- verilog/soc_memory.sv
`timescale 1ns/1ns

module soc_memory (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_stb,
    input  logic           mem_rom_sel,
    input  logic           we,
    input  soc_pkg::addr_t adr,
    input  soc_pkg::word_t dat_w,
    input  soc_pkg::sel_t  sel,
    output soc_pkg::word_t mem_rdata,
    output logic           mem_ack
);
    import soc_pkg::*;

    word_t rom [0:(1 << rom_bits) - 1];
    word_t ram [0:(1 << ram_bits) - 1];

    logic                rom_access;
    logic                ram_access;
    logic [rom_bits-1:0] rom_index;
    logic [ram_bits-1:0] ram_index;

    initial begin
        $readmemh("rom.hex", rom);
    end

    // both memories are word addressed, so the byte offset is dropped.
    assign rom_index = adr[rom_bits+1:2];
    assign ram_index = adr[ram_bits+1:2];

    assign rom_access = mem_stb && !mem_ack && mem_rom_sel;
    assign ram_access = mem_stb && !mem_ack && !mem_rom_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= mem_stb && !mem_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (rom_access) begin
            mem_rdata <= rom[rom_index];
        end else if (ram_access) begin
            mem_rdata <= ram[ram_index];
        end
    end

    // a write takes only the selected lanes; the read above sees the old word.
    always_ff @(posedge clk) begin
        if (ram_access && we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (sel[lane]) begin
                    ram[ram_index][8*lane +: 8] <= dat_w[8*lane +: 8];
                end
            end
        end
    end

endmodule

//--- verilog/soc_pkg.sv
package soc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus and data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  sel_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  region_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the region code sits in the top nibble of the byte address.
    localparam int region_start_bit = 28;

    localparam region_t region_rom         = 4'd1;
    localparam region_t region_ram         = 4'd2;
    localparam region_t region_led         = 4'd3;
    localparam region_t region_uart_data   = 4'd4;
    localparam region_t region_uart_status = 4'd5;

    localparam int rom_bits = 4;
    localparam int ram_bits = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // uart
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int fifo_bits      = 4;
    localparam int uart_clock_div = 8;

    localparam int status_tx_full_bit  = 0;
    localparam int status_rx_empty_bit = 1;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } uart_rx_state_t;

endpackage

//--- verilog/uart_port.sv
`timescale 1ns/1ns

module uart_port (
    input  logic           clk,
    input  logic           rst,
    input  logic           uart_stb,
    input  logic           uart_status_sel,
    input  logic           we,
    input  soc_pkg::word_t dat_w,
    output soc_pkg::word_t uart_rdata,
    output logic           uart_ack,
    output logic           tx,
    input  logic           rx
);
    import soc_pkg::*;

    byte_t tx_head;
    byte_t rx_head;
    byte_t rx_byte;
    word_t status;
    logic  tx_full;
    logic  tx_empty;
    logic  tx_pop;
    logic  rx_full;
    logic  rx_empty;
    logic  rx_push;
    logic  go;
    logic  data_wr;
    logic  data_rd;
    logic  status_rd;

    // a data access waits here while its FIFO cannot serve it.
    assign go        = uart_stb && !uart_ack;
    assign data_wr   = go && !uart_status_sel && we && !tx_full;
    assign data_rd   = go && !uart_status_sel && !we && !rx_empty;
    assign status_rd = go && uart_status_sel;

    always_comb begin
        status                      = '0;
        status[status_tx_full_bit]  = tx_full;
        status[status_rx_empty_bit] = rx_empty;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uart_ack <= 1'b0;
        end else begin
            uart_ack <= data_wr || data_rd || status_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (data_rd) begin
            uart_rdata <= word_t'(rx_head);
        end else if (status_rd) begin
            uart_rdata <= status;
        end
    end

    byte_fifo tx_fifo (
        .clk(clk), .rst(rst), .push(data_wr), .pop(tx_pop), .wdata(dat_w[7:0]),
        .rdata(tx_head), .full(tx_full), .empty(tx_empty)
    );

    uart_tx i_uart_tx (
        .clk(clk), .rst(rst), .empty(tx_empty), .data(tx_head), .pop(tx_pop), .tx(tx)
    );

    // a byte that finds the receive FIFO full is lost.
    byte_fifo rx_fifo (
        .clk(clk), .rst(rst), .push(rx_push && !rx_full), .pop(data_rd), .wdata(rx_byte),
        .rdata(rx_head), .full(rx_full), .empty(rx_empty)
    );

    uart_rx i_uart_rx (
        .clk(clk), .rst(rst), .rx(rx), .data(rx_byte), .push(rx_push)
    );

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
    input  logic           clk,
    input  logic           rst,
    input  logic           rx,
    output soc_pkg::byte_t data,
    output logic           push
);
    import soc_pkg::*;

    uart_rx_state_t                    state;
    byte_t                             shift;
    logic [$clog2(uart_clock_div)-1:0] cnt;
    logic [2:0]                        bit_idx;
    logic                              rx_meta;
    logic                              rx_sync;
    logic                              half_point;
    logic                              bit_end;

    assign half_point = (int'(cnt) == uart_clock_div / 2 - 1);
    assign bit_end    = (int'(cnt) == uart_clock_div - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            state   <= rx_idle;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            cnt     <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;
                    end
                end
                // a glitch shorter than half a bit is not a start bit.
                rx_start: begin
                    if (half_point) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= rx_idle;
                    end
                end
            endcase
        end
    end

    // bits arrive LSB first and enter at the top.
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign data = shift;

    // a low stop bit means a framing error, and the byte is not pushed.
    assign push = (state == rx_stop) && bit_end && rx_sync;

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
    input  logic           clk,
    input  logic           rst,
    input  logic           empty,
    input  soc_pkg::byte_t data,
    output logic           pop,
    output logic           tx
);
    import soc_pkg::*;

    uart_tx_state_t                    state;
    byte_t                             shift;
    logic [$clog2(uart_clock_div)-1:0] cnt;
    logic [2:0]                        bit_idx;
    logic                              bit_end;

    assign bit_end = (int'(cnt) == uart_clock_div - 1);

    // the head byte is taken as soon as the line is idle.
    assign pop = (state == tx_idle) && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= tx_idle;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= (state == tx_idle || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                tx_idle: begin
                    if (pop) begin
                        state <= tx_start;
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        state   <= tx_data;
                        bit_idx <= '0;
                    end
                end
                tx_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= tx_stop;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= tx_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= data;
        end else if (state == tx_data && bit_end) begin
            shift <= shift >> 1;
        end
    end

    assign tx = (state == tx_start) ? 1'b0 : (state == tx_data) ? shift[0] : 1'b1;

endmodule
